/* design/plicPkg.sv */
////////////////////////////////////////
// shared widths, types and register map
// one hart with machine and supervisor contexts
// seven level sources, IDs 1 to 7, ID 0 is none
// all registers are full 32-bit words
////////////////////////////////////////

`default_nettype none

package plicPkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////

  // source count, fixed for this design
  localparam int numSrc = 7;

  // field widths
  localparam int addrW = 24;
  localparam int dataW = 32;
  localparam int prioW = 3;
  localparam int idW   = 3;

  ////////////////////////////////////////
  // types
  ////////////////////////////////////////

  // APB byte offset and data word
  typedef logic [addrW-1:0] apbAddrT;
  typedef logic [dataW-1:0] apbDataT;

  // priority or threshold
  typedef logic [prioW-1:0] prioT;

  // source ID, zero means no interrupt
  typedef logic [idW-1:0] srcIdT;

  // one bit per source, bit 0 is not a source
  typedef logic [numSrc:1] srcVecT;

  // all priorities packed, source n in slice n-1
  typedef logic [numSrc*prioW-1:0] prioVecT;

  ////////////////////////////////////////
  // register map, byte offsets
  ////////////////////////////////////////

  // priority of source n sits at 4*n
  localparam apbAddrT addrPrioBase = 24'h000000;
  localparam apbAddrT addrPending  = 24'h001000;

  // per-context enable masks
  localparam apbAddrT addrEnableM  = 24'h002000;
  localparam apbAddrT addrEnableS  = 24'h002080;

  // machine context threshold and claim/complete
  localparam apbAddrT addrThreshM  = 24'h200000;
  localparam apbAddrT addrClaimM   = 24'h200004;

  // supervisor context threshold and claim/complete
  localparam apbAddrT addrThreshS  = 24'h201000;
  localparam apbAddrT addrClaimS   = 24'h201004;

endpackage

`default_nettype wire

/* design/plicGateways.sv */
////////////////////////////////////////
// level-triggered gateways, one per source
// sources must already be synchronous to PCLK
// pending stays latched until claimed
// no new request while a source is in progress
////////////////////////////////////////

`default_nettype none

module plicGateways (
  input  wire logic            PCLK,
  input  wire logic            PRESETn,
  input  wire plicPkg::srcVecT intrSources,
  input  wire plicPkg::srcVecT claimSet,
  input  wire plicPkg::srcVecT completeClr,
  output plicPkg::srcVecT      pending
);

  // per-source state
  plicPkg::srcVecT inProgress;
  plicPkg::srcVecT pendingNext;
  plicPkg::srcVecT inProgressNext;
  plicPkg::srcVecT newRequest;

  ////////////////////////////////////////
  // next-state logic
  ////////////////////////////////////////

  // a high line only requests when its source is idle
  assign newRequest = intrSources & ~inProgress;

  // claim wins over a fresh request on the same edge
  // so pending drops as in-progress rises
  assign pendingNext = (pending | newRequest) & ~claimSet;

  // complete clears first, a claim on the same edge sets again
  assign inProgressNext = (inProgress & ~completeClr) | claimSet;

  ////////////////////////////////////////
  // state registers
  ////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      pending    <= '0;
      inProgress <= '0;
    end else begin
      pending    <= pendingNext;
      inProgress <= inProgressNext;
    end
  end

  // after a complete the line is sampled again on the next edge
  // since in-progress is still set at the complete edge itself

endmodule

`default_nettype wire

/* design/plicArbiter.sv */
////////////////////////////////////////
// per-context arbiter, purely combinational
// highest priority wins, ties go to lowest ID
// priority 0 never takes part
// extInt only when winner is above threshold
////////////////////////////////////////

`default_nettype none

module plicArbiter (
  input  wire plicPkg::srcVecT  pending,
  input  wire plicPkg::srcVecT  enable,
  input  wire plicPkg::prioVecT priorities,
  input  wire plicPkg::prioT    threshold,
  output plicPkg::srcIdT        claimId,
  output logic                  extInt
);

  // unpacked view of the priority vector
  plicPkg::prioT   srcPrio [plicPkg::numSrc:1];

  // sources that may win in this context
  plicPkg::srcVecT active;

  // highest priority among active sources
  plicPkg::prioT   maxPrio;

  // active sources sitting at that priority
  plicPkg::srcVecT atMax;

  ////////////////////////////////////////
  // per-source qualification
  ////////////////////////////////////////

  always_comb begin
    for (int n = 1; n <= plicPkg::numSrc; n++) begin
      // slice n-1 of the packed vector holds source n
      srcPrio[n] = priorities[(n-1)*plicPkg::prioW +: plicPkg::prioW];
      // pending, enabled here and priority above zero
      active[n]  = pending[n] & enable[n] & (srcPrio[n] != '0);
    end
  end

  ////////////////////////////////////////
  // maximum priority
  ////////////////////////////////////////

  // stays zero when nothing is active
  always_comb begin
    maxPrio = '0;
    for (int n = 1; n <= plicPkg::numSrc; n++) begin
      if (active[n] && (srcPrio[n] > maxPrio)) begin
        maxPrio = srcPrio[n];
      end
    end
  end

  always_comb begin
    for (int n = 1; n <= plicPkg::numSrc; n++) begin
      atMax[n] = active[n] & (srcPrio[n] == maxPrio);
    end
  end

  ////////////////////////////////////////
  // winner and interrupt line
  ////////////////////////////////////////

  // scan downwards so the lowest ID is the last to land
  always_comb begin
    claimId = '0;
    for (int n = plicPkg::numSrc; n >= 1; n--) begin
      if (atMax[n]) begin
        claimId = plicPkg::srcIdT'(n);
      end
    end
  end

  // maxPrio is the winner's priority, zero with no winner
  // so a zero threshold with nothing active keeps the line low
  assign extInt = (maxPrio > threshold);

endmodule

`default_nettype wire

/* design/plicRegFile.sv */
////////////////////////////////////////
// APB register file, no wait states, no PSLVERR
// reads decode in setup phase, PRDATA is registered
// writes land at the end of the access phase
// word access only, PADDR[1:0] is ignored
// unmapped addresses read zero and drop writes
////////////////////////////////////////

`default_nettype none

module plicRegFile (
  input  wire logic             PCLK,
  input  wire logic             PRESETn,
  input  wire logic             PSEL,
  input  wire logic             PENABLE,
  input  wire logic             PWRITE,
  input  wire plicPkg::apbAddrT PADDR,
  input  wire plicPkg::apbDataT PWDATA,
  output plicPkg::apbDataT      PRDATA,
  output logic                  PREADY,
  input  wire plicPkg::srcVecT  pending,
  input  wire plicPkg::srcIdT   claimIdM,
  input  wire plicPkg::srcIdT   claimIdS,
  output plicPkg::prioVecT      priorities,
  output plicPkg::srcVecT       enableM,
  output plicPkg::srcVecT       enableS,
  output plicPkg::prioT         threshM,
  output plicPkg::prioT         threshS,
  output plicPkg::srcVecT       claimSet,
  output plicPkg::srcVecT       completeClr
);

  // APB phase qualifiers
  logic             wrEn;
  logic             rdEn;

  // word-aligned offset
  plicPkg::apbAddrT entry;

  // priority window decode
  logic             prioHit;
  plicPkg::srcIdT   prioIdx;

  // read data before the output register
  plicPkg::apbDataT rdData;

  // ID named by a complete write
  plicPkg::srcIdT   completeId;

  // per-context strobes before merging
  plicPkg::srcVecT  claimM;
  plicPkg::srcVecT  claimS;
  plicPkg::srcVecT  completeM;
  plicPkg::srcVecT  completeS;

  // one-hot vector for a source ID, ID 0 gives all zero
  function automatic plicPkg::srcVecT idToVec(input plicPkg::srcIdT id);
    plicPkg::srcVecT vec;
    vec = '0;
    for (int n = 1; n <= plicPkg::numSrc; n++) begin
      if (id == plicPkg::srcIdT'(n)) begin
        vec[n] = 1'b1;
      end
    end
    return vec;
  endfunction

  ////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////

  // never stalls
  assign PREADY = 1'b1;

  // write commits in the access phase
  assign wrEn = PSEL & PENABLE & PWRITE;

  // read is taken one cycle early, in setup
  assign rdEn = PSEL & ~PENABLE & ~PWRITE;

  assign entry = {PADDR[plicPkg::addrW-1:2], 2'b00};

  // priorities live in 0x04..0x1C, slot 0 has no source
  assign prioIdx = entry[4:2];
  assign prioHit = (entry[plicPkg::addrW-1:5] == plicPkg::addrPrioBase[plicPkg::addrW-1:5])
                   && (prioIdx != '0);

  ////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////

  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      priorities <= '0;
      enableM    <= '0;
      enableS    <= '0;
      threshM    <= '0;
      threshS    <= '0;
    end else if (wrEn) begin
      case (entry)
        // bit 0 is not a source and is never stored
        plicPkg::addrEnableM: enableM <= PWDATA[plicPkg::numSrc:1];
        plicPkg::addrEnableS: enableS <= PWDATA[plicPkg::numSrc:1];
        plicPkg::addrThreshM: threshM <= PWDATA[plicPkg::prioW-1:0];
        plicPkg::addrThreshS: threshS <= PWDATA[plicPkg::prioW-1:0];
        default: begin
          if (prioHit) begin
            for (int n = 1; n <= plicPkg::numSrc; n++) begin
              if (prioIdx == plicPkg::srcIdT'(n)) begin
                priorities[(n-1)*plicPkg::prioW +: plicPkg::prioW] <=
                  PWDATA[plicPkg::prioW-1:0];
              end
            end
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // read path
  ////////////////////////////////////////

  // upper bits above each field are zero-filled by the casts
  always_comb begin
    rdData = '0;
    case (entry)
      plicPkg::addrPending: rdData = plicPkg::apbDataT'({pending, 1'b0});
      plicPkg::addrEnableM: rdData = plicPkg::apbDataT'({enableM, 1'b0});
      plicPkg::addrEnableS: rdData = plicPkg::apbDataT'({enableS, 1'b0});
      plicPkg::addrThreshM: rdData = plicPkg::apbDataT'(threshM);
      plicPkg::addrThreshS: rdData = plicPkg::apbDataT'(threshS);
      // claim returns the same ID that is strobed below
      plicPkg::addrClaimM:  rdData = plicPkg::apbDataT'(claimIdM);
      plicPkg::addrClaimS:  rdData = plicPkg::apbDataT'(claimIdS);
      default: begin
        if (prioHit) begin
          for (int n = 1; n <= plicPkg::numSrc; n++) begin
            if (prioIdx == plicPkg::srcIdT'(n)) begin
              rdData = plicPkg::apbDataT'(
                priorities[(n-1)*plicPkg::prioW +: plicPkg::prioW]);
            end
          end
        end
      end
    endcase
  end

  // held through the access phase, zero otherwise
  always_ff @(posedge PCLK) begin
    if (!PRESETn) begin
      PRDATA <= '0;
    end else if (rdEn) begin
      PRDATA <= rdData;
    end else begin
      PRDATA <= '0;
    end
  end

  ////////////////////////////////////////
  // claim and complete strobes
  ////////////////////////////////////////

  assign completeId = PWDATA[plicPkg::idW-1:0];

  // claim pulses in the setup phase of a claim read
  assign claimM = (rdEn && (entry == plicPkg::addrClaimM)) ? idToVec(claimIdM) : '0;
  assign claimS = (rdEn && (entry == plicPkg::addrClaimS)) ? idToVec(claimIdS) : '0;

  // complete pulses in the access phase of a write
  assign completeM = (wrEn && (entry == plicPkg::addrClaimM)) ? idToVec(completeId) : '0;
  assign completeS = (wrEn && (entry == plicPkg::addrClaimS)) ? idToVec(completeId) : '0;

  // both contexts merge onto one strobe each
  assign claimSet    = claimM | claimS;
  assign completeClr = completeM | completeS;

endmodule

`default_nettype wire

/* design/plicApb.sv */
////////////////////////////////////////
// PLIC top on an APB slave port
// one hart, machine and supervisor contexts
// seven level sources on intrSources[7:1]
// PREADY is always high
////////////////////////////////////////

`default_nettype none

module plicApb (
  input  wire logic             PCLK,
  input  wire logic             PRESETn,
  input  wire logic             PSEL,
  input  wire logic             PENABLE,
  input  wire logic             PWRITE,
  input  wire plicPkg::apbAddrT PADDR,
  input  wire plicPkg::apbDataT PWDATA,
  output plicPkg::apbDataT      PRDATA,
  output logic                  PREADY,
  input  wire plicPkg::srcVecT  intrSources,
  output logic                  mExtInt,
  output logic                  sExtInt
);

  // configuration from the register file
  plicPkg::prioVecT priorities;
  plicPkg::srcVecT  enableM;
  plicPkg::srcVecT  enableS;
  plicPkg::prioT    threshM;
  plicPkg::prioT    threshS;

  // shared gateway state
  plicPkg::srcVecT  pending;

  // arbiter winners
  plicPkg::srcIdT   claimIdM;
  plicPkg::srcIdT   claimIdS;

  // single-cycle gateway strobes
  plicPkg::srcVecT  claimSet;
  plicPkg::srcVecT  completeClr;

  ////////////////////////////////////////
  // register file and gateways
  ////////////////////////////////////////

  plicRegFile regFile (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .PSEL        (PSEL),
    .PENABLE     (PENABLE),
    .PWRITE      (PWRITE),
    .PADDR       (PADDR),
    .PWDATA      (PWDATA),
    .PRDATA      (PRDATA),
    .PREADY      (PREADY),
    .pending     (pending),
    .claimIdM    (claimIdM),
    .claimIdS    (claimIdS),
    .priorities  (priorities),
    .enableM     (enableM),
    .enableS     (enableS),
    .threshM     (threshM),
    .threshS     (threshS),
    .claimSet    (claimSet),
    .completeClr (completeClr)
  );

  plicGateways gateways (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .intrSources (intrSources),
    .claimSet    (claimSet),
    .completeClr (completeClr),
    .pending     (pending)
  );

  ////////////////////////////////////////
  // context arbiters
  ////////////////////////////////////////

  // machine context
  plicArbiter arbM (
    .pending    (pending),
    .enable     (enableM),
    .priorities (priorities),
    .threshold  (threshM),
    .claimId    (claimIdM),
    .extInt     (mExtInt)
  );

  // supervisor context
  plicArbiter arbS (
    .pending    (pending),
    .enable     (enableS),
    .priorities (priorities),
    .threshold  (threshS),
    .claimId    (claimIdS),
    .extInt     (sExtInt)
  );

endmodule

`default_nettype wire

/* sim/plicApbTasks.svh */
////////////////////////////////////////
// APB tasks, reference model, error counts
// included inside plicApbTb, uses its signals
// every task starts and ends on a falling edge
////////////////////////////////////////

`ifndef PLIC_APB_TASKS_SVH
`define PLIC_APB_TASKS_SVH

// failures by kind
int readErrors    = 0;
int intErrors     = 0;
int timeoutErrors = 0;

// programmed and latched state as the model sees it
plicPkg::prioT   modelPrio [1:plicPkg::numSrc];
plicPkg::srcVecT modelEnM;
plicPkg::srcVecT modelEnS;
plicPkg::srcVecT modelPend;
plicPkg::srcVecT modelBusy;
plicPkg::prioT   modelThM;
plicPkg::prioT   modelThS;

// first ID met at a strictly higher priority keeps a tie
function automatic plicPkg::srcIdT bestSource(input plicPkg::srcVecT en);
  plicPkg::srcIdT best;
  plicPkg::prioT  bestPrio;
  best     = '0;
  bestPrio = '0;
  for (int n = 1; n <= plicPkg::numSrc; n++) begin
    if (modelPend[n] && en[n] && (modelPrio[n] > bestPrio)) begin
      best     = plicPkg::srcIdT'(n);
      bestPrio = modelPrio[n];
    end
  end
  return best;
endfunction

// line is up when a winner beats the threshold
function automatic logic raised(input plicPkg::srcVecT en, input plicPkg::prioT th);
  plicPkg::srcIdT id;
  id = bestSource(en);
  return (id != '0) && (modelPrio[id] > th);
endfunction

// expected read data for any offset, holes read zero
function automatic plicPkg::apbDataT regValue(input plicPkg::apbAddrT addr);
  plicPkg::apbDataT v;
  v = '0;
  case (addr)
    plicPkg::addrPending: v = plicPkg::apbDataT'({modelPend, 1'b0});
    plicPkg::addrEnableM: v = plicPkg::apbDataT'({modelEnM, 1'b0});
    plicPkg::addrEnableS: v = plicPkg::apbDataT'({modelEnS, 1'b0});
    plicPkg::addrThreshM: v = plicPkg::apbDataT'(modelThM);
    plicPkg::addrThreshS: v = plicPkg::apbDataT'(modelThS);
    plicPkg::addrClaimM:  v = plicPkg::apbDataT'(bestSource(modelEnM));
    plicPkg::addrClaimS:  v = plicPkg::apbDataT'(bestSource(modelEnS));
    default: begin
      for (int n = 1; n <= plicPkg::numSrc; n++) begin
        if (addr == plicPkg::apbAddrT'(4 * n)) begin
          v = plicPkg::apbDataT'(modelPrio[n]);
        end
      end
    end
  endcase
  return v;
endfunction

task automatic updateExpected();
  expM = raised(modelEnM, modelThM);
  expS = raised(modelEnS, modelThS);
endtask

// one APB transfer, setup then access, then idle
task automatic apbXfer(input logic write, input plicPkg::apbAddrT addr,
                       input plicPkg::apbDataT wdata, input logic check);
  @(negedge PCLK);
  // taken before a claim edge can change the model
  expRd   = regValue(addr);
  PSEL    = 1'b1;
  PENABLE = 1'b0;
  PWRITE  = write;
  PADDR   = addr;
  PWDATA  = wdata;
  @(negedge PCLK);
  PENABLE = 1'b1;
  chkRd   = check && !write;
  rdData  = PRDATA;
  @(negedge PCLK);
  PSEL    = 1'b0;
  PENABLE = 1'b0;
  PWRITE  = 1'b0;
  chkRd   = 1'b0;
endtask

// write, then mirror the register map into the model
task automatic configWrite(input plicPkg::apbAddrT addr, input plicPkg::apbDataT data);
  apbXfer(1'b1, addr, data, 1'b0);
  case (addr)
    plicPkg::addrEnableM: modelEnM = data[plicPkg::numSrc:1];
    plicPkg::addrEnableS: modelEnS = data[plicPkg::numSrc:1];
    plicPkg::addrThreshM: modelThM = data[plicPkg::prioW-1:0];
    plicPkg::addrThreshS: modelThS = data[plicPkg::prioW-1:0];
    default: begin
      for (int n = 1; n <= plicPkg::numSrc; n++) begin
        if (addr == plicPkg::apbAddrT'(4 * n)) begin
          modelPrio[n] = data[plicPkg::prioW-1:0];
        end
      end
    end
  endcase
  updateExpected();
endtask

`endif

/* sim/plicApbTb.sv */
////////////////////////////////////////
// testbench for the APB PLIC top
// concurrent assertions compare with a model
// random stimulus from a fixed seed
////////////////////////////////////////

`default_nettype none

module plicApbTb;

  timeunit 1ns;
  timeprecision 1ps;

  // DUT ports, names match for implicit binding
  logic             PCLK;
  logic             PRESETn;
  logic             PSEL;
  logic             PENABLE;
  logic             PWRITE;
  plicPkg::apbAddrT PADDR;
  plicPkg::apbDataT PWDATA;
  plicPkg::apbDataT PRDATA;
  logic             PREADY;
  plicPkg::srcVecT  intrSources;
  logic             mExtInt;
  logic             sExtInt;

  // checker enables and expected values
  logic             chkRd;
  logic             chkInt;
  logic             expM;
  logic             expS;
  plicPkg::apbDataT expRd;
  plicPkg::apbDataT rdData;
  plicPkg::srcVecT  src;
  int               seed = 70793;
  int               polls;

  // priorities 1 to 7, context registers, pending, six holes, claims last
  localparam plicPkg::apbAddrT regList [20] = '{
    24'h000004, 24'h000008, 24'h00000C, 24'h000010, 24'h000014, 24'h000018,
    24'h00001C, plicPkg::addrEnableM, plicPkg::addrEnableS, plicPkg::addrThreshM,
    plicPkg::addrThreshS, plicPkg::addrPending, 24'h000000, 24'h000020, 24'h001004,
    24'h002004, 24'h200008, 24'h300000, plicPkg::addrClaimM, plicPkg::addrClaimS
  };

  `include "plicApbTasks.svh"

  plicApb dut0 (.*);

  initial begin
    PCLK = 1'b0;
    forever #10 PCLK = ~PCLK;
  end

  ////////////////////////////////////////
  // checkers
  ////////////////////////////////////////

  // access phase data of a checked read
  assert property (@(posedge PCLK) chkRd |-> (PRDATA == expRd))
    else begin
      readErrors++;
      $display("ERROR @%0t: read of %h gave %h, expected %h", $time,
               $sampled(PADDR), $sampled(PRDATA), $sampled(expRd));
    end

  // no read data outside read access phases
  assert property (@(posedge PCLK) disable iff (!PRESETn)
                   !(PSEL && PENABLE && !PWRITE) |-> (PRDATA == '0))
    else begin
      readErrors++;
      $display("ERROR @%0t: PRDATA %h outside a read access phase", $time,
               $sampled(PRDATA));
    end

  // no wait states on any access
  assert property (@(posedge PCLK) disable iff (!PRESETn) (PSEL && PENABLE) |-> PREADY)
    else begin
      readErrors++;
      $display("ERROR @%0t: PREADY low in an access phase", $time);
    end

  // both lines follow the model, each on its own context
  assert property (@(posedge PCLK) chkInt |-> (mExtInt == expM) && (sExtInt == expS))
    else begin
      intErrors++;
      $display("ERROR @%0t: mExtInt %b sExtInt %b, expected %b %b", $time,
               $sampled(mExtInt), $sampled(sExtInt), $sampled(expM), $sampled(expS));
    end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  task automatic resetDut(input int cycles);
    chkInt      = 1'b0;
    intrSources = '0;
    PRESETn     = 1'b0;
    repeat (cycles) @(negedge PCLK);
    PRESETn   = 1'b1;
    modelEnM  = '0;
    modelEnS  = '0;
    modelThM  = '0;
    modelThS  = '0;
    modelPend = '0;
    modelBusy = '0;
    foreach (modelPrio[n]) begin
      modelPrio[n] = '0;
    end
    updateExpected();
    chkInt = 1'b1;
  endtask

  // gateways latch one edge after the lines change
  task automatic driveSources(input plicPkg::srcVecT lines);
    @(negedge PCLK);
    intrSources = lines;
    @(negedge PCLK);
    modelPend = modelPend | (lines & ~modelBusy);
    updateExpected();
  endtask

  // the winner moves from pending to in progress
  task automatic claimRead(input plicPkg::apbAddrT addr);
    plicPkg::srcIdT id;
    chkInt = 1'b0;
    id     = plicPkg::srcIdT'(regValue(addr));
    apbXfer(1'b0, addr, '0, 1'b1);
    if (id != '0) begin
      modelPend[id] = 1'b0;
      modelBusy[id] = 1'b1;
    end
    updateExpected();
    chkInt = 1'b1;
  endtask

  task automatic completeWrite(input plicPkg::apbAddrT addr, input plicPkg::srcIdT id);
    apbXfer(1'b1, addr, plicPkg::apbDataT'(id), 1'b0);
    modelBusy[id] = 1'b0;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    PSEL        = 1'b0;
    PENABLE     = 1'b0;
    PWRITE      = 1'b0;
    PADDR       = '0;
    PWDATA      = '0;
    intrSources = '0;
    chkRd       = 1'b0;
    expRd       = '0;
    rdData      = '0;
    resetDut(10);

    // everything reads zero after reset, claims give ID 0
    for (int i = 0; i < 20; i++) begin
      apbXfer(1'b0, regList[i], '0, 1'b1);
    end

    // random words read back masked, holes and pending ignore writes
    for (int i = 0; i < 18; i++) begin
      configWrite(regList[i], $random(seed));
      apbXfer(1'b0, regList[i], '0, 1'b1);
    end

    // a short pulse stays latched in pending
    driveSources(plicPkg::srcVecT'($random(seed)));
    driveSources('0);
    apbXfer(1'b0, plicPkg::addrPending, '0, 1'b1);

    // random rounds, one claim per context
    for (int r = 0; r < 24; r++) begin
      resetDut(2);
      for (int i = 0; i < 11; i++) begin
        configWrite(regList[i], $random(seed));
      end
      driveSources(plicPkg::srcVecT'($random(seed)));
      repeat (3) @(negedge PCLK);
      claimRead(plicPkg::addrClaimM);
      claimRead(plicPkg::addrClaimS);
      repeat (3) @(negedge PCLK);
    end

    // claimed source stays clear while its line is held
    resetDut(2);
    configWrite(24'h00000C, 32'd5);
    configWrite(24'h000014, 32'd2);
    configWrite(plicPkg::addrEnableM, 32'h28);
    // supervisor only sees source 6, left at priority 0
    configWrite(plicPkg::addrEnableS, 32'h40);
    src    = '0;
    src[3] = 1'b1;
    src[5] = 1'b1;
    src[6] = 1'b1;
    driveSources(src);
    // no winner and no line in supervisor while machine is raised
    claimRead(plicPkg::addrClaimS);
    claimRead(plicPkg::addrClaimM);
    apbXfer(1'b0, plicPkg::addrPending, '0, 1'b1);
    repeat (5) @(negedge PCLK);
    apbXfer(1'b0, plicPkg::addrPending, '0, 1'b1);
    claimRead(plicPkg::addrClaimM);

    // source 5 drops before its complete, source 3 stays high
    chkInt = 1'b0;
    src[5] = 1'b0;
    driveSources(src);
    completeWrite(plicPkg::addrClaimM, 3'd3);
    completeWrite(plicPkg::addrClaimS, 3'd5);
    polls  = 0;
    rdData = '0;
    while (!rdData[3] && (polls < 20)) begin
      apbXfer(1'b0, plicPkg::addrPending, '0, 1'b0);
      polls++;
    end
    if (!rdData[3]) begin
      timeoutErrors++;
      $display("TIMEOUT: pending bit 3 did not return after its complete");
    end
    modelPend[3] = 1'b1;
    updateExpected();
    chkInt = 1'b1;
    apbXfer(1'b0, plicPkg::addrPending, '0, 1'b1);
    repeat (3) @(negedge PCLK);

    $display("errors: read %0d, interrupt %0d, timeout %0d",
             readErrors, intErrors, timeoutErrors);
    if ((readErrors + intErrors + timeoutErrors) == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* plicApb.f */
+incdir+sim
design/plicPkg.sv
design/plicGateways.sv
design/plicArbiter.sv
design/plicRegFile.sv
design/plicApb.sv
sim/plicApbTb.sv
